/* design/issue_pkg.sv */
package issue_pkg;

    // datapath and rename widths
    localparam int XLEN       = 32;
    localparam int ROB_TAG_W  = 4;
    localparam int REG_ADDR_W = 5;
    localparam int ISSUE_OP_W = 4;

    // tag zero marks a ready value with no producer
    localparam logic [ROB_TAG_W-1:0] TAG_NONE = '0;

    // plain vector types
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ROB_TAG_W-1:0]  rob_tag_t;
    typedef logic [2:0]            funct3_t;

    // ALU packets hold an alu_op_e value here
    // compare and load/store packets hold {1'b0, funct3}
    typedef logic [ISSUE_OP_W-1:0] issue_op_t;

    // funct3 codes the decoder has to single out
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_SR   = 3'b101;

    // major opcodes handled by the stage
    typedef enum logic [6:0] {
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // code is {funct7[5], funct3}
    typedef enum logic [ISSUE_OP_W-1:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

    // which consumer an instruction goes to
    // class_none is accepted and dropped without a tag
    typedef enum logic [1:0] {
        class_none = 2'b00,
        class_alu  = 2'b01,
        class_cmp  = 2'b10,
        class_mem  = 2'b11
    } issue_class_e;

endpackage

/* design/instr_field_decode.sv */
module instr_field_decode
    import issue_pkg::*;
(
    input  word_t        instr_i,

    output reg_addr_t    rs1_o,
    output reg_addr_t    rs2_o,
    output reg_addr_t    rd_o,
    output issue_class_e class_o,
    output issue_op_t    op_o,
    output word_t        imm_o,
    output logic         rs1_is_pc_o,
    output logic         rs2_is_imm_o,
    output logic         store_o,
    output logic         writes_rd_o
);

    opcode_e   opcode;
    funct3_t   funct3;
    logic      funct7_b5;
    logic      rd_zero;
    logic      alt_op;
    alu_op_e   alu_op;
    word_t     i_imm;
    word_t     s_imm;
    word_t     b_imm;
    word_t     u_imm;

    // raw fields
    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rs1_o     = instr_i[19:15];
    assign rs2_o     = instr_i[24:20];
    assign rd_o      = instr_i[11:7];
    assign rd_zero   = (instr_i[11:7] == '0);

    // sign-extended immediates
    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'h000};

    // funct7 bit 5 only matters for sub and the right shifts
    // addi ignores it, there is no subi
    always_comb begin
        alt_op = 1'b0;
        if (funct3 == F3_SR) begin
            alt_op = funct7_b5;
        end else if (funct3 == F3_ADD && opcode == op_reg) begin
            alt_op = funct7_b5;
        end
        alu_op = alu_op_e'({alt_op, funct3});
    end

    // issue class, op code and immediate per opcode
    always_comb begin
        class_o = class_none;
        op_o    = {1'b0, funct3};
        imm_o   = '0;
        case (opcode)
            op_auipc: begin
                // pc + u_imm on the ALU
                class_o = rd_zero ? class_none : class_alu;
                op_o    = alu_add;
                imm_o   = u_imm;
            end
            op_reg, op_imm: begin
                op_o  = alu_op;
                imm_o = (opcode == op_imm) ? i_imm : '0;
                // set-less-than forms are not handled
                if (funct3 == F3_SLT || funct3 == F3_SLTU) begin
                    class_o = class_none;
                end else if (rd_zero) begin
                    class_o = class_none;
                end else begin
                    class_o = class_alu;
                end
            end
            op_br: begin
                class_o = class_cmp;
                imm_o   = b_imm;
            end
            op_load: begin
                // load to x0 has no visible effect
                class_o = rd_zero ? class_none : class_mem;
                imm_o   = i_imm;
            end
            op_store: begin
                class_o = class_mem;
                imm_o   = s_imm;
            end
            default: begin
                class_o = class_none;
            end
        endcase
    end

    // operand routing flags
    assign rs1_is_pc_o  = (opcode == op_auipc);
    assign rs2_is_imm_o = (opcode == op_imm) || (opcode == op_auipc) ||
                          (opcode == op_load);
    assign store_o      = (opcode == op_store);

    // only ALU results and loads get a renamed destination
    assign writes_rd_o  = (class_o == class_alu) ||
                          (class_o == class_mem && opcode == op_load);

endmodule

/* design/operand_resolve.sv */
module operand_resolve
    import issue_pkg::*;
(
    input  word_t    rf_rs1_value_i,
    input  word_t    rf_rs2_value_i,
    input  rob_tag_t rf_rs1_tag_i,
    input  rob_tag_t rf_rs2_tag_i,
    input  logic     rob_lookup1_ready_i,
    input  logic     rob_lookup2_ready_i,
    input  word_t    rob_lookup1_value_i,
    input  word_t    rob_lookup2_value_i,

    output rob_tag_t rob_lookup1_tag_o,
    output rob_tag_t rob_lookup2_tag_o,
    output word_t    rs1_value_o,
    output word_t    rs2_value_o,
    output rob_tag_t rs1_tag_o,
    output rob_tag_t rs2_tag_o
);

    logic rs1_hit;
    logic rs2_hit;

    // pending tags go straight to the ROB lookup ports
    // a zero tag looks up nothing
    assign rob_lookup1_tag_o = rf_rs1_tag_i;
    assign rob_lookup2_tag_o = rf_rs2_tag_i;

    // producer already finished but not yet committed
    assign rs1_hit = (rf_rs1_tag_i != TAG_NONE) && rob_lookup1_ready_i;
    assign rs2_hit = (rf_rs2_tag_i != TAG_NONE) && rob_lookup2_ready_i;

    // take the ROB value and drop the tag on a hit
    assign rs1_value_o = rs1_hit ? rob_lookup1_value_i : rf_rs1_value_i;
    assign rs1_tag_o   = rs1_hit ? TAG_NONE : rf_rs1_tag_i;
    assign rs2_value_o = rs2_hit ? rob_lookup2_value_i : rf_rs2_value_i;
    assign rs2_tag_o   = rs2_hit ? TAG_NONE : rf_rs2_tag_i;

endmodule

/* design/issue_ctrl.sv */
module issue_ctrl
    import issue_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // instruction queue
    input  logic         instr_valid_i,
    input  word_t        pc_i,
    output logic         instr_ready_o,

    // decoded fields
    input  issue_class_e class_i,
    input  issue_op_t    op_i,
    input  word_t        imm_i,
    input  reg_addr_t    rd_i,
    input  logic         rs1_is_pc_i,
    input  logic         rs2_is_imm_i,
    input  logic         store_i,
    input  logic         writes_rd_i,

    // resolved operands
    input  word_t        rs1_value_i,
    input  rob_tag_t     rs1_tag_i,
    input  word_t        rs2_value_i,
    input  rob_tag_t     rs2_tag_i,

    // reorder buffer
    input  rob_tag_t     rob_free_tag_i,
    output logic         rob_alloc_o,
    output word_t        rob_alloc_pc_o,
    output reg_addr_t    rob_alloc_rd_o,
    output logic         rob_alloc_store_o,

    // register file rename
    output logic         rename_we_o,
    output reg_addr_t    rename_rd_o,
    output rob_tag_t     rename_tag_o,

    // consumers
    input  logic         alu_full_i,
    input  logic         cmp_full_i,
    input  logic         lsb_full_i,
    output logic         alu_valid_o,
    output logic         cmp_valid_o,
    output logic         lsb_valid_o,

    // shared dispatch bus
    output issue_op_t    issue_op_o,
    output rob_tag_t     issue_rob_tag_o,
    output word_t        issue_rs1_value_o,
    output rob_tag_t     issue_rs1_tag_o,
    output word_t        issue_rs2_value_o,
    output rob_tag_t     issue_rs2_tag_o,
    output word_t        issue_imm_o,
    output word_t        issue_pc_o,
    output logic         lsb_store_o
);

    logic     target_full;
    logic     accept;
    logic     issue;
    word_t    op1_value;
    rob_tag_t op1_tag;
    word_t    op2_value;
    rob_tag_t op2_tag;

    // full flag of whichever consumer the class selects
    always_comb begin
        case (class_i)
            class_alu: target_full = alu_full_i;
            class_cmp: target_full = cmp_full_i;
            class_mem: target_full = lsb_full_i;
            default:   target_full = 1'b0;
        endcase
    end

    // discarded instructions never wait
    assign instr_ready_o = (class_i == class_none) ||
                           (!target_full && rob_free_tag_i != TAG_NONE);
    assign accept        = instr_valid_i && instr_ready_o;
    assign issue         = accept && (class_i != class_none);

    // ROB entry, same cycle as the accept
    assign rob_alloc_o       = issue;
    assign rob_alloc_pc_o    = pc_i;
    assign rob_alloc_rd_o    = writes_rd_i ? rd_i : '0;
    assign rob_alloc_store_o = store_i;

    // rd now waits on the new tag
    assign rename_we_o  = issue && writes_rd_i;
    assign rename_rd_o  = rd_i;
    assign rename_tag_o = rob_free_tag_i;

    // auipc takes pc as the first operand
    assign op1_value = rs1_is_pc_i ? pc_i : rs1_value_i;
    assign op1_tag   = rs1_is_pc_i ? TAG_NONE : rs1_tag_i;

    // immediate ops, auipc and loads take the immediate as second operand
    assign op2_value = rs2_is_imm_i ? imm_i : rs2_value_i;
    assign op2_tag   = rs2_is_imm_i ? TAG_NONE : rs2_tag_i;

    // one-cycle valid pulse toward the selected consumer
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
            lsb_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= issue && (class_i == class_alu);
            cmp_valid_o <= issue && (class_i == class_cmp);
            lsb_valid_o <= issue && (class_i == class_mem);
        end
    end

    // packet is only meaningful while a valid is high
    always_ff @(posedge clk) begin
        if (issue) begin
            issue_op_o        <= op_i;
            issue_rob_tag_o   <= rob_free_tag_i;
            issue_rs1_value_o <= op1_value;
            issue_rs1_tag_o   <= op1_tag;
            issue_rs2_value_o <= op2_value;
            issue_rs2_tag_o   <= op2_tag;
            issue_imm_o       <= imm_i;
            issue_pc_o        <= pc_i;
            lsb_store_o       <= store_i;
        end
    end

endmodule

/* design/decode_issue_top.sv */
module decode_issue_top
    import issue_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // instruction queue
    input  logic      instr_valid_i,
    input  word_t     instr_i,
    input  word_t     pc_i,
    output logic      instr_ready_o,

    // register file read
    output reg_addr_t rf_rs1_addr_o,
    output reg_addr_t rf_rs2_addr_o,
    input  word_t     rf_rs1_value_i,
    input  rob_tag_t  rf_rs1_tag_i,
    input  word_t     rf_rs2_value_i,
    input  rob_tag_t  rf_rs2_tag_i,

    // reorder buffer lookup
    output rob_tag_t  rob_lookup1_tag_o,
    output rob_tag_t  rob_lookup2_tag_o,
    input  logic      rob_lookup1_ready_i,
    input  word_t     rob_lookup1_value_i,
    input  logic      rob_lookup2_ready_i,
    input  word_t     rob_lookup2_value_i,

    // reorder buffer allocation
    input  rob_tag_t  rob_free_tag_i,
    output logic      rob_alloc_o,
    output word_t     rob_alloc_pc_o,
    output reg_addr_t rob_alloc_rd_o,
    output logic      rob_alloc_store_o,

    // register file rename
    output logic      rename_we_o,
    output reg_addr_t rename_rd_o,
    output rob_tag_t  rename_tag_o,

    // consumers
    input  logic      alu_full_i,
    input  logic      cmp_full_i,
    input  logic      lsb_full_i,
    output logic      alu_valid_o,
    output logic      cmp_valid_o,
    output logic      lsb_valid_o,
    output issue_op_t issue_op_o,
    output rob_tag_t  issue_rob_tag_o,
    output word_t     issue_rs1_value_o,
    output rob_tag_t  issue_rs1_tag_o,
    output word_t     issue_rs2_value_o,
    output rob_tag_t  issue_rs2_tag_o,
    output word_t     issue_imm_o,
    output word_t     issue_pc_o,
    output logic      lsb_store_o
);

    // decoder to issue control
    reg_addr_t    dec_rd;
    issue_class_e dec_class;
    issue_op_t    dec_op;
    word_t        dec_imm;
    logic         dec_rs1_is_pc;
    logic         dec_rs2_is_imm;
    logic         dec_store;
    logic         dec_writes_rd;

    // resolved operands
    word_t        res_rs1_value;
    word_t        res_rs2_value;
    rob_tag_t     res_rs1_tag;
    rob_tag_t     res_rs2_tag;

    // register fields address the register file directly
    instr_field_decode u_decode (
        .instr_i      (instr_i),
        .rs1_o        (rf_rs1_addr_o),
        .rs2_o        (rf_rs2_addr_o),
        .rd_o         (dec_rd),
        .class_o      (dec_class),
        .op_o         (dec_op),
        .imm_o        (dec_imm),
        .rs1_is_pc_o  (dec_rs1_is_pc),
        .rs2_is_imm_o (dec_rs2_is_imm),
        .store_o      (dec_store),
        .writes_rd_o  (dec_writes_rd)
    );

    operand_resolve u_resolve (
        .rf_rs1_value_i      (rf_rs1_value_i),
        .rf_rs2_value_i      (rf_rs2_value_i),
        .rf_rs1_tag_i        (rf_rs1_tag_i),
        .rf_rs2_tag_i        (rf_rs2_tag_i),
        .rob_lookup1_ready_i (rob_lookup1_ready_i),
        .rob_lookup2_ready_i (rob_lookup2_ready_i),
        .rob_lookup1_value_i (rob_lookup1_value_i),
        .rob_lookup2_value_i (rob_lookup2_value_i),
        .rob_lookup1_tag_o   (rob_lookup1_tag_o),
        .rob_lookup2_tag_o   (rob_lookup2_tag_o),
        .rs1_value_o         (res_rs1_value),
        .rs2_value_o         (res_rs2_value),
        .rs1_tag_o           (res_rs1_tag),
        .rs2_tag_o           (res_rs2_tag)
    );

    issue_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .instr_valid_i     (instr_valid_i),
        .pc_i              (pc_i),
        .instr_ready_o     (instr_ready_o),
        .class_i           (dec_class),
        .op_i              (dec_op),
        .imm_i             (dec_imm),
        .rd_i              (dec_rd),
        .rs1_is_pc_i       (dec_rs1_is_pc),
        .rs2_is_imm_i      (dec_rs2_is_imm),
        .store_i           (dec_store),
        .writes_rd_i       (dec_writes_rd),
        .rs1_value_i       (res_rs1_value),
        .rs1_tag_i         (res_rs1_tag),
        .rs2_value_i       (res_rs2_value),
        .rs2_tag_i         (res_rs2_tag),
        .rob_free_tag_i    (rob_free_tag_i),
        .rob_alloc_o       (rob_alloc_o),
        .rob_alloc_pc_o    (rob_alloc_pc_o),
        .rob_alloc_rd_o    (rob_alloc_rd_o),
        .rob_alloc_store_o (rob_alloc_store_o),
        .rename_we_o       (rename_we_o),
        .rename_rd_o       (rename_rd_o),
        .rename_tag_o      (rename_tag_o),
        .alu_full_i        (alu_full_i),
        .cmp_full_i        (cmp_full_i),
        .lsb_full_i        (lsb_full_i),
        .alu_valid_o       (alu_valid_o),
        .cmp_valid_o       (cmp_valid_o),
        .lsb_valid_o       (lsb_valid_o),
        .issue_op_o        (issue_op_o),
        .issue_rob_tag_o   (issue_rob_tag_o),
        .issue_rs1_value_o (issue_rs1_value_o),
        .issue_rs1_tag_o   (issue_rs1_tag_o),
        .issue_rs2_value_o (issue_rs2_value_o),
        .issue_rs2_tag_o   (issue_rs2_tag_o),
        .issue_imm_o       (issue_imm_o),
        .issue_pc_o        (issue_pc_o),
        .lsb_store_o       (lsb_store_o)
    );

endmodule

/* dv/decode_issue_properties.sv */
module decode_issue_properties (
    input logic clk,
    input logic rst,
    input logic instr_valid_i,
    input logic instr_ready_o,
    input logic rob_alloc_o,
    input logic alu_valid_o,
    input logic cmp_valid_o,
    input logic lsb_valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic any_valid;

    assign any_valid = alu_valid_o || cmp_valid_o || lsb_valid_o;

    // allocation only on a real handshake
    a_alloc_on_accept: assert property (@(posedge clk) disable iff (rst)
        rob_alloc_o |-> (instr_valid_i && instr_ready_o))
        else $error("ROB allocation without an accepted instruction");

    // shared bus, one consumer at a time
    a_one_dispatch: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_valid_o, cmp_valid_o, lsb_valid_o}))
        else $error("more than one dispatch valid in a cycle");

    // every allocation dispatches on the next cycle
    a_dispatch_follows: assert property (@(posedge clk) disable iff (rst)
        rob_alloc_o |=> any_valid)
        else $error("no dispatch one cycle after an allocation");

    // and nothing dispatches without one
    a_dispatch_has_alloc: assert property (@(posedge clk) disable iff (rst)
        any_valid |-> $past(rob_alloc_o))
        else $error("dispatch valid without an allocation the cycle before");

endmodule

bind decode_issue_top decode_issue_properties u_props (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .rob_alloc_o   (rob_alloc_o),
    .alu_valid_o   (alu_valid_o),
    .cmp_valid_o   (cmp_valid_o),
    .lsb_valid_o   (lsb_valid_o)
);

/* dv/decode_issue_tb.sv */
module decode_issue_tb
    import issue_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PER_TEST    = 40;
    localparam int NUM_TESTS   = 7;
    localparam int TOTAL_INSTR = PER_TEST * NUM_TESTS;
    localparam int WATCHDOG_NS = 40 * 20 * TOTAL_INSTR + 400;

    // expected packet per accepted instruction
    // kind is 0 for none, 1 alu, 2 cmp and 3 load/store
    typedef struct packed {
        logic [1:0] kind;
        logic       wr;
        issue_op_t  op;
        rob_tag_t   tag;
        word_t      rs1v;
        rob_tag_t   rs1t;
        word_t      rs2v;
        rob_tag_t   rs2t;
        word_t      imm;
        word_t      pc;
        logic       store;
    } exp_t;

    logic clk;
    logic rst;
    logic instr_valid_i, instr_ready_o;
    word_t instr_i, pc_i;
    reg_addr_t rf_rs1_addr_o, rf_rs2_addr_o;
    word_t rf_rs1_value_i, rf_rs2_value_i;
    rob_tag_t rf_rs1_tag_i, rf_rs2_tag_i;
    rob_tag_t rob_lookup1_tag_o, rob_lookup2_tag_o;
    logic rob_lookup1_ready_i, rob_lookup2_ready_i;
    word_t rob_lookup1_value_i, rob_lookup2_value_i;
    rob_tag_t rob_free_tag_i;
    logic rob_alloc_o, rob_alloc_store_o;
    word_t rob_alloc_pc_o;
    reg_addr_t rob_alloc_rd_o;
    logic rename_we_o;
    reg_addr_t rename_rd_o;
    rob_tag_t rename_tag_o;
    logic alu_full_i, cmp_full_i, lsb_full_i;
    logic alu_valid_o, cmp_valid_o, lsb_valid_o;
    issue_op_t issue_op_o;
    rob_tag_t issue_rob_tag_o, issue_rs1_tag_o, issue_rs2_tag_o;
    word_t issue_rs1_value_o, issue_rs2_value_o, issue_imm_o, issue_pc_o;
    logic lsb_store_o;

    // register file and ROB models
    word_t    rf_val [32];
    rob_tag_t rf_tag [32];
    word_t    rob_val [16];
    logic     rob_ready [16];
    rob_tag_t free_ctr;
    logic     no_free;
    logic     stress;
    logic     all_ready;

    integer seed;
    exp_t   expq[$];
    string  cur_test;
    int     test_checks, test_errs, total_checks, total_errs;

    decode_issue_top u_dut (.*);

    always #10 clk = ~clk;

    // combinational reads of the models
    assign rf_rs1_value_i      = rf_val[rf_rs1_addr_o];
    assign rf_rs1_tag_i        = rf_tag[rf_rs1_addr_o];
    assign rf_rs2_value_i      = rf_val[rf_rs2_addr_o];
    assign rf_rs2_tag_i        = rf_tag[rf_rs2_addr_o];
    assign rob_lookup1_ready_i = rob_ready[rob_lookup1_tag_o];
    assign rob_lookup1_value_i = rob_val[rob_lookup1_tag_o];
    assign rob_lookup2_ready_i = rob_ready[rob_lookup2_tag_o];
    assign rob_lookup2_value_i = rob_val[rob_lookup2_tag_o];
    assign rob_free_tag_i      = no_free ? 4'd0 : free_ctr;

    task automatic check_val(string what, logic [31:0] exp_v, logic [31:0] act_v);
        test_checks = test_checks + 1;
        if (exp_v !== act_v) begin
            test_errs = test_errs + 1;
            $display("Error %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
        end
    endtask

    // operand as seen at accept
    // the ROB value wins once the producer is done
    function automatic word_t src_value(reg_addr_t a);
        if (rf_tag[a] != 4'd0 && rob_ready[rf_tag[a]]) return rob_val[rf_tag[a]];
        return rf_val[a];
    endfunction

    function automatic rob_tag_t src_tag(reg_addr_t a);
        if (rf_tag[a] != 4'd0 && rob_ready[rf_tag[a]]) return 4'd0;
        return rf_tag[a];
    endfunction

    // expected outcome straight from the RV32I encoding
    function automatic exp_t ref_issue(word_t ins, word_t pc, rob_tag_t tag);
        exp_t       e;
        logic [2:0] f3;
        logic       rd_nz;
        f3      = ins[14:12];
        rd_nz   = (ins[11:7] != 5'd0);
        e       = '0;
        e.tag   = tag;
        e.pc    = pc;
        e.op    = {1'b0, f3};
        e.rs1v  = src_value(ins[19:15]);
        e.rs1t  = src_tag(ins[19:15]);
        e.rs2v  = src_value(ins[24:20]);
        e.rs2t  = src_tag(ins[24:20]);
        case (ins[6:0])
            7'b0010111: begin
                e.kind = rd_nz ? 2'd1 : 2'd0;
                e.op   = 4'd0;
                e.imm  = {ins[31:12], 12'h000};
                e.rs1v = pc;
                e.rs1t = 4'd0;
                e.rs2v = e.imm;
                e.rs2t = 4'd0;
            end
            7'b0110011: begin
                e.kind = (rd_nz && f3 != 3'd2 && f3 != 3'd3) ? 2'd1 : 2'd0;
                e.op   = {ins[30] & (f3 == 3'd0 || f3 == 3'd5), f3};
            end
            7'b0010011: begin
                e.kind = (rd_nz && f3 != 3'd2 && f3 != 3'd3) ? 2'd1 : 2'd0;
                e.op   = {ins[30] & (f3 == 3'd5), f3};
                e.imm  = {{21{ins[31]}}, ins[30:20]};
                e.rs2v = e.imm;
                e.rs2t = 4'd0;
            end
            7'b1100011: begin
                e.kind = 2'd2;
                e.imm  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'b0000011: begin
                e.kind = rd_nz ? 2'd3 : 2'd0;
                e.imm  = {{21{ins[31]}}, ins[30:20]};
                e.rs2v = e.imm;
                e.rs2t = 4'd0;
            end
            7'b0100011: begin
                e.kind  = 2'd3;
                e.store = 1'b1;
                e.imm   = {{21{ins[31]}}, ins[30:25], ins[11:7]};
            end
            default: e.kind = 2'd0;
        endcase
        // only ALU results and loads rename rd
        e.wr = (e.kind == 2'd1) || (e.kind == 2'd3 && !e.store);
        return e;
    endfunction

    // random instruction of one group
    // modes 4 and 5 mix groups 0 to 3
    task automatic gen_instr(input int mode, output word_t ins);
        logic [31:0] r;
        logic [2:0]  f3_tab [8];
        logic [2:0]  f3;
        int          m;
        f3_tab = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd5};
        r   = $random(seed);
        ins = $random(seed);
        f3  = f3_tab[r[17:15]];
        m   = (mode == 4 || mode == 5) ? int'(r[20:19]) : mode;
        ins[11:7]  = (r[14:10] == 5'd0) ? 5'd1 : r[14:10];
        ins[14:12] = f3;
        case (m)
            0: begin
                ins[6:0]   = 7'b0110011;
                ins[31:25] = {1'b0, r[21] & (f3 == 3'd0 || f3 == 3'd5), 5'b0};
            end
            1: begin
                ins[6:0] = r[18] ? 7'b0010111 : 7'b0010011;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    ins[31:25] = {1'b0, r[21] & (f3 == 3'd5), 5'b0};
                end
            end
            2: ins[6:0] = 7'b1100011;
            3: ins[6:0] = r[18] ? 7'b0000011 : 7'b0100011;
            default: begin
                // discards are unsupported opcodes, rd zero and set-less-than
                case (r[20:19])
                    2'd0: ins[6:0] = r[18] ? 7'b0110111 : 7'b1101111;
                    2'd1: begin
                        ins[6:0]  = 7'b0110011;
                        ins[11:7] = 5'd0;
                    end
                    2'd2: begin
                        ins[6:0]  = 7'b0000011;
                        ins[11:7] = 5'd0;
                    end
                    default: begin
                        ins[6:0]   = 7'b0010011;
                        ins[14:12] = {2'b01, r[18]};
                    end
                endcase
            end
        endcase
    endtask

    // full flags, free tag and ROB contents for the next cycle
    task automatic randomize_env();
        logic [31:0] r;
        r = $random(seed);
        alu_full_i = stress ? r[0] : (r[2:0] == 3'd0);
        cmp_full_i = stress ? r[1] : (r[5:3] == 3'd0);
        lsb_full_i = stress ? r[2] : (r[8:6] == 3'd0);
        no_free    = stress ? (r[10:9] == 2'd0) : 1'b0;
        for (int k = 0; k < 16; k++) begin
            rob_ready[k] = all_ready ? 1'b1 : r[k+12];
            rob_val[k]   = $random(seed);
        end
    endtask

    // hold one instruction until accepted and then update the models
    task automatic issue_one(word_t ins, word_t pc);
        logic done;
        exp_t e;
        instr_valid_i = 1'b1;
        instr_i       = ins;
        pc_i          = pc;
        done          = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (instr_ready_o) begin
                e = ref_issue(ins, pc, rob_free_tag_i);
                check_val("rob_alloc", 32'(e.kind != 2'd0), 32'(rob_alloc_o));
                check_val("rename_we", 32'(e.wr), 32'(rename_we_o));
                if (e.wr) begin
                    check_val("rename_rd", 32'(ins[11:7]), 32'(rename_rd_o));
                    check_val("rename_tag", 32'(e.tag), 32'(rename_tag_o));
                end
                if (e.kind != 2'd0) begin
                    check_val("alloc_pc", pc, rob_alloc_pc_o);
                    // branches and stores have no destination register
                    check_val("alloc_rd", e.wr ? 32'(ins[11:7]) : 32'd0,
                              32'(rob_alloc_rd_o));
                    check_val("alloc_store", 32'(e.store), 32'(rob_alloc_store_o));
                    expq.push_back(e);
                end
                done = 1'b1;
            end else if (rob_alloc_o) begin
                test_errs = test_errs + 1;
                $display("Error %s: ROB allocated while the instruction was stalled", cur_test);
            end
            @(posedge clk);
            #2;
            if (done && e.wr) rf_tag[ins[11:7]] = e.tag;
            if (done && e.kind != 2'd0) begin
                free_ctr = (free_ctr == 4'd15) ? 4'd1 : free_ctr + 4'd1;
            end
            randomize_env();
        end
    endtask

    task automatic run_test(string name, int mode, logic stress_in, logic ready_in);
        word_t ins;
        cur_test    = name;
        test_checks = 0;
        test_errs   = 0;
        stress      = stress_in;
        all_ready   = ready_in;
        for (int i = 0; i < PER_TEST; i++) begin
            gen_instr(mode, ins);
            issue_one(ins, pc_i + 32'd4);
        end
        instr_valid_i = 1'b0;
        // wait for the last dispatch to be compared
        while (expq.size() != 0) @(negedge clk);
        // next test drives again just after a rising edge
        @(posedge clk);
        #2;
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errs);
        total_checks = total_checks + test_checks;
        total_errs   = total_errs + test_errs;
    endtask

    // every dispatch against the oldest expectation
    initial begin
        exp_t       e;
        logic [1:0] kind;
        forever begin
            @(negedge clk);
            if (alu_valid_o || cmp_valid_o || lsb_valid_o) begin
                kind = alu_valid_o ? 2'd1 : (cmp_valid_o ? 2'd2 : 2'd3);
                if (expq.size() == 0) begin
                    test_errs = test_errs + 1;
                    $display("Error %s: dispatch with no accepted instruction", cur_test);
                end else begin
                    e = expq.pop_front();
                    check_val("target", 32'(e.kind), 32'(kind));
                    check_val("op", 32'(e.op), 32'(issue_op_o));
                    check_val("rob_tag", 32'(e.tag), 32'(issue_rob_tag_o));
                    check_val("rs1_value", e.rs1v, issue_rs1_value_o);
                    check_val("rs1_tag", 32'(e.rs1t), 32'(issue_rs1_tag_o));
                    check_val("rs2_value", e.rs2v, issue_rs2_value_o);
                    check_val("rs2_tag", 32'(e.rs2t), 32'(issue_rs2_tag_o));
                    check_val("imm", e.imm, issue_imm_o);
                    check_val("pc", e.pc, issue_pc_o);
                    if (kind == 2'd3) check_val("store", 32'(e.store), 32'(lsb_store_o));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish in the time allowed");
        $display("Errors found");
        $finish;
    end

    initial begin
        seed          = 32'h1f74;
        clk           = 1'b0;
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = 32'h0000_1000;
        free_ctr      = 4'd1;
        stress        = 1'b0;
        all_ready     = 1'b0;
        total_checks  = 0;
        total_errs    = 0;
        cur_test      = "reset";
        for (int k = 0; k < 32; k++) begin
            rf_val[k] = (k == 0) ? 32'd0 : $random(seed);
            rf_tag[k] = 4'd0;
        end
        randomize_env();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        run_test("alu_reg", 0, 1'b0, 1'b0);
        run_test("alu_imm_auipc", 1, 1'b0, 1'b0);
        run_test("branch", 2, 1'b0, 1'b0);
        run_test("load_store", 3, 1'b0, 1'b0);
        run_test("rob_forward", 4, 1'b0, 1'b1);
        run_test("stall_order", 5, 1'b1, 1'b0);
        run_test("discard", 6, 1'b1, 1'b0);
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/issue_pkg.sv
design/instr_field_decode.sv
design/operand_resolve.sv
design/issue_ctrl.sv
design/decode_issue_top.sv
dv/decode_issue_properties.sv
dv/decode_issue_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = decode_issue_tb
FLIST = verilog.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)
